// File: bench/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen
#(
        parameter int periodNs = 40,
        parameter int resetCycles = 4
)
(
        output logic clk,
        output logic rst
);

        initial
        begin
                clk = 1'b0;
                forever
                        #(periodNs / 2) clk = ~clk;
        end

        initial
        begin
                rst = 1'b1;
                repeat (resetCycles) @(posedge clk);
                rst <= 1'b0;    // Released on an edge, the DUT sees it from the next one.
        end

endmodule

`default_nettype wire

// File: bench/hockeyTb.sv
`timescale 1ns/1ps
`default_nettype none

module hockeyTb;
        import hockeyPkg::*;

        localparam int untilRunning = 0;
        localparam int untilLedA = 1;
        localparam int untilLedB = 2;
        localparam int untilEnds = 3;
        localparam int untilDark = 4;
        localparam int untilDash = 5;

        logic clk;
        logic rst;
        playerCtrl playerA;
        playerCtrl playerB;
        logic ledA;
        logic ledB;
        logic [4:0] ledX;
        segCode ssd0;
        segCode ssd1;
        segCode ssd2;
        segCode ssd4;
        puckPos pos;

        coordX modelX;
        coordY modelY;
        vertDir modelDir;
        int goalsA;
        int goalsB;
        int checks;
        int errors;
        bit timedOut;
        int mark;
        coordY row;
        vertDir dir;

        clockGen clockGen_inst (.clk(clk), .rst(rst));

        hockeyTop #(
                .stepTicks(6),
                .blinkTicks(3)
        ) hockeyTop_inst (
                .clk(clk), .rst(rst), .playerA(playerA), .playerB(playerB),
                .ledA(ledA), .ledB(ledB), .ledX(ledX),
                .ssd0(ssd0), .ssd1(ssd1), .ssd2(ssd2), .ssd4(ssd4), .pos(pos)
        );

        // **************************************************
        // Checks and waits
        // **************************************************

        function automatic segCode segFor(input int value);
                case (value)
                        0:
                                return segZero;
                        1:
                                return segOne;
                        2:
                                return segTwo;
                        3:
                                return segThree;
                        4:
                                return segFour;
                        default:
                                return segBlank;
                endcase
        endfunction

        task automatic checkValue(input string name, input logic [31:0] got,
                                  input logic [31:0] expected);
                if (!timedOut)
                begin
                        checks++;
                        assert (got === expected)
                        else
                        begin
                                errors++;
                                $display("MISMATCH %0s: got 0x%0h, expected 0x%0h", name, got,
                                         expected);
                        end
                end
        endtask

        task automatic checkPos();
                checkValue("pos", pos, {modelX, modelY});
        endtask

        task automatic checkTally();
                checkValue("ssd0", ssd0, segFor(goalsB));
                checkValue("ssd1", ssd1, segDash);
                checkValue("ssd2", ssd2, segFor(goalsA));
        endtask

        task automatic endTest(input string name, input int errorsBefore);
                $display("%0s: %0s", name, (errors == errorsBefore) ? "ok" : "failed");
        endtask

        task automatic reportTimeout(input string what);
                $display("TIMEOUT: %0s", what);
                errors++;
                timedOut = 1'b1;
        endtask

        function automatic bit eventSeen(input int kind);
                case (kind)
                        untilRunning:
                                return !rst;
                        untilLedA:
                                return ledA;
                        untilLedB:
                                return ledB;
                        untilEnds:
                                return ledX == 5'b10001;
                        untilDark:
                                return ledX == 5'b00000;
                        untilDash:
                                return ssd1 == segDash;
                        default:
                                return 1'b0;
                endcase
        endfunction

        // Outputs are looked at on the falling edge, away from the driving edge.
        task automatic waitFor(input int kind, input int limit, input string what);
                int n;
                n = 0;
                @(negedge clk);
                while (!timedOut && !eventSeen(kind))
                begin
                        if (n == limit)
                                reportTimeout(what);
                        else
                        begin
                                @(negedge clk);
                                n++;
                        end
                end
        endtask

        // **************************************************
        // Reference model of the puck
        // **************************************************

        task automatic applyRow(input vertDir d);
                modelDir = d;
                if (d == 2'd1)
                begin
                        if (modelY == 3'd4)
                        begin
                                modelDir = 2'd2;
                                modelY = 3'd3;
                        end
                        else
                                modelY = modelY + 3'd1;
                end
                else if (d == 2'd2)
                begin
                        if (modelY == 3'd0)
                        begin
                                modelDir = 2'd1;
                                modelY = 3'd1;
                        end
                        else
                                modelY = modelY - 3'd1;
                end
        endtask

        task automatic pressHit(input bit forB, input coordY r, input vertDir d);
                @(posedge clk);
                if (forB)
                        playerB <= {1'b1, d, r};
                else
                        playerA <= {1'b1, d, r};
                @(posedge clk);
                playerA.hit <= 1'b0;
                playerB.hit <= 1'b0;
        endtask

        task automatic followPuck(input bit towardB);
                coordX target;
                int n;
                target = towardB ? 3'd4 : 3'd0;
                n = 0;
                while (!timedOut && modelX != target)
                begin
                        if (n == 60)
                                reportTimeout("puck did not reach the far column");
                        else
                        begin
                                @(negedge clk);
                                n++;
                                if (pos.x != modelX)
                                begin
                                        modelX = towardB ? modelX + 3'd1 : modelX - 3'd1;
                                        applyRow(modelDir);
                                end
                                checkPos();
                                checkValue("ledX", ledX, 5'b00001 << modelX);
                                checkValue("ssd4", ssd4, segFor(modelY));
                        end
                end
        endtask

        task automatic returnBy(input bit byB);
                vertDir d;
                d = vertDir'($urandom % 4);
                pressHit(byB, modelY, d);
                modelX = byB ? 3'd3 : 3'd1;
                applyRow(d);
                @(negedge clk);
                checkPos();
        endtask

        task automatic winPointForA();
                coordY r;
                vertDir d;
                waitFor(untilLedB, 30, "B was never prompted to serve");
                r = coordY'($urandom % 5);
                d = vertDir'($urandom % 4);
                pressHit(1'b1, r, d);
                modelX = 3'd4;
                modelY = r;
                modelDir = d;
                @(negedge clk);
                checkPos();
                followPuck(1'b0);
                returnBy(1'b0);
                followPuck(1'b1);
                waitFor(untilEnds, 20, "no goal after B missed");  // B lets it through.
                goalsA++;
                checkTally();
        endtask

        // **************************************************
        // Test sequence
        // **************************************************

        initial
        begin
                playerA = '0;
                playerB = '0;
                checks = 0;
                errors = 0;
                timedOut = 1'b0;
                goalsA = 0;
                goalsB = 0;
                modelX = 3'd0;
                modelY = 3'd0;
                modelDir = 2'd0;
                void'($urandom(33));

                mark = errors;
                waitFor(untilRunning, 20, "reset was never released");
                checkValue("ledA", ledA, 1'b0);
                checkValue("ledB", ledB, 1'b0);
                checkValue("ledX", ledX, 5'b00000);
                checkValue("ssd0", ssd0, segBlank);
                checkValue("ssd1", ssd1, segBlank);
                checkValue("ssd2", ssd2, segBlank);
                checkValue("ssd4", ssd4, segBlank);
                checkPos();
                endTest("reset", mark);

                mark = errors;
                pressHit(1'b0, 3'd0, 2'd0);
                waitFor(untilDash, 10, "score display never appeared");
                checkTally();
                waitFor(untilLedA, 20, "A was never prompted to serve");
                checkValue("ledB", ledB, 1'b0);
                pressHit(1'b0, 3'd5, 2'd0);     // Row 5 is off the board.
                repeat (3)
                begin
                        @(negedge clk);
                        checkValue("ledA", ledA, 1'b1);
                        checkPos();
                end
                endTest("serve choice", mark);

                mark = errors;
                row = coordY'($urandom % 5);
                dir = vertDir'($urandom % 4);
                pressHit(1'b0, row, dir);
                modelY = row;
                modelDir = dir;
                @(negedge clk);
                checkPos();
                followPuck(1'b1);
                endTest("travel and bounce", mark);

                mark = errors;
                returnBy(1'b1);
                followPuck(1'b0);
                returnBy(1'b0);
                followPuck(1'b1);
                endTest("return", mark);

                mark = errors;
                waitFor(untilEnds, 20, "no goal after B missed");
                goalsA++;
                checkTally();
                waitFor(untilLedB, 20, "B was never prompted to serve");
                checkValue("ledA", ledA, 1'b0);
                endTest("goal", mark);

                mark = errors;
                winPointForA();
                winPointForA();
                repeat (2)
                begin
                        waitFor(untilDark, 30, "end display never went dark");
                        checkTally();
                        waitFor(untilEnds, 30, "end display never lit again");
                        checkTally();
                end
                endTest("match end", mark);

                $display("checks: %0d, errors: %0d", checks, errors);
                if (errors == 0)
                        $display("PASS: all tests");
                else
                        $display("FAIL: see errors above");
                $finish;
        end

endmodule

`default_nettype wire

// File: source/gameControl.sv
`timescale 1ns/1ps
`default_nettype none

module gameControl
#(
        parameter int stepTicks = 100,
        parameter int blinkTicks = 25
)
(
        input wire clk,
        input wire rst,
        input wire hockeyPkg::playerCtrl playerA,
        input wire hockeyPkg::playerCtrl playerB,
        input wire hockeyPkg::puckPos pos,
        output hockeyPkg::gamePhase phase,
        output hockeyPkg::score scoreA,
        output hockeyPkg::score scoreB,
        output hockeyPkg::puckCmd cmd,
        output logic toB,
        output hockeyPkg::playerCtrl ctrl
);
        import hockeyPkg::*;

        localparam int maxTicks = (stepTicks > blinkTicks) ? stepTicks : blinkTicks;
        localparam int tickWidth = $clog2(maxTicks + 2);
        localparam logic [tickWidth-1:0] stepLast = tickWidth'(stepTicks);
        localparam logic [tickWidth-1:0] blinkLast = tickWidth'(blinkTicks);
        localparam score winScore = 2'd3;

        gamePhase phaseNext;
        logic [tickWidth-1:0] tick;
        logic [tickWidth-1:0] tickLast;
        logic periodEnd;
        logic serveA;
        logic hitA;
        logic hitB;
        logic catchA;
        logic catchB;

        assign tickLast = (phase == finish || phase == blink) ? blinkLast : stepLast;
        assign periodEnd = (tick == tickLast);

        // A serve counts only from a row on the board.
        assign hitA = playerA.hit && (playerA.row <= lastRow);
        assign hitB = playerB.hit && (playerB.row <= lastRow);

        // A return needs the responder's paddle on the puck's row.
        assign catchA = playerA.hit && (pos.y == playerA.row);
        assign catchB = playerB.hit && (pos.y == playerB.row);

        // **************************************************
        // Next phase and puck commands
        // **************************************************

        always_comb
        begin
                phaseNext = phase;
                cmd = hold;
                toB = 1'b0;
                ctrl = playerA;
                case (phase)
                        idle:
                                if (playerA.hit != playerB.hit)
                                        phaseNext = showScore;
                        showScore:
                                if (periodEnd)
                                        phaseNext = serveA ? waitHitA : waitHitB;
                        waitHitA:
                                if (hitA)
                                begin
                                        cmd = serve;
                                        toB = 1'b1;
                                        phaseNext = sendToB;
                                end
                        waitHitB:
                                if (hitB)
                                begin
                                        cmd = serve;
                                        ctrl = playerB;
                                        phaseNext = sendToA;
                                end
                        sendToB:
                                if (periodEnd)
                                begin
                                        cmd = step;
                                        toB = 1'b1;
                                        if (pos.x == lastCol - 3'd1)
                                                phaseNext = respondB;  // Lands on B's column.
                                end
                        sendToA:
                                if (periodEnd)
                                begin
                                        cmd = step;
                                        if (pos.x == 3'd1)
                                                phaseNext = respondA;
                                end
                        respondB:
                                if (catchB)
                                begin
                                        cmd = ret;
                                        ctrl = playerB;
                                        phaseNext = sendToA;
                                end
                                else if (periodEnd)
                                        phaseNext = goalA;
                        respondA:
                                if (catchA)
                                begin
                                        cmd = ret;
                                        toB = 1'b1;
                                        phaseNext = sendToB;
                                end
                                else if (periodEnd)
                                        phaseNext = goalB;
                        goalA:
                                if (periodEnd)
                                        phaseNext = (scoreA == winScore) ? finish : waitHitB;
                        goalB:
                                if (periodEnd)
                                        phaseNext = (scoreB == winScore) ? finish : waitHitA;
                        finish:
                                if (periodEnd)
                                        phaseNext = blink;
                        blink:
                                if (periodEnd)
                                        phaseNext = finish;
                        default:
                                phaseNext = idle;
                endcase
        end

        // **************************************************
        // Phase, timer and scores
        // **************************************************

        always_ff @(posedge clk or posedge rst)
        begin
                if (rst)
                begin
                        phase <= idle;
                        tick <= '0;
                        serveA <= 1'b0;
                        scoreA <= '0;
                        scoreB <= '0;
                end
                else
                begin
                        phase <= phaseNext;
                        if (periodEnd || phaseNext != phase)
                                tick <= '0;     // Every phase and every step starts a fresh period.
                        else
                                tick <= tick + 1'b1;
                        if (phase == idle)
                                serveA <= playerA.hit;
                        if (phase == respondB && phaseNext == goalA)
                                scoreA <= scoreA + 2'd1;
                        if (phase == respondA && phaseNext == goalB)
                                scoreB <= scoreB + 2'd1;
                end
        end

endmodule

`default_nettype wire

// File: source/hockeyPkg.sv
`default_nettype none

package hockeyPkg;

        // **************************************************
        // Board geometry and value widths
        // **************************************************

        typedef logic [2:0] coordX;
        typedef logic [2:0] coordY;
        typedef logic [1:0] vertDir;    // 1 is up, 2 is down, 0 and 3 are straight.
        typedef logic [1:0] score;
        typedef logic [6:0] segCode;    // Active low, segment a in the top bit.

        localparam coordY lastRow = 3'd4;
        localparam coordX lastCol = 3'd4;

        typedef struct packed {
                logic hit;
                vertDir dir;
                coordY row;
        } playerCtrl;

        typedef struct packed {
                coordX x;
                coordY y;
        } puckPos;

        // **************************************************
        // Game phases and puck commands
        // **************************************************

        typedef enum logic [3:0] {
                idle, showScore, waitHitA, waitHitB, sendToB, sendToA,
                respondA, respondB, goalA, goalB, finish, blink
        } gamePhase;

        typedef enum logic [1:0] {hold, serve, step, ret} puckCmd;

        localparam segCode segZero = 7'b0000001;
        localparam segCode segOne = 7'b1001111;
        localparam segCode segTwo = 7'b0010010;
        localparam segCode segThree = 7'b0000110;
        localparam segCode segFour = 7'b1001100;
        localparam segCode segBlank = 7'b1111111;
        localparam segCode segDash = 7'b1111110;       // Middle bar only.

endpackage

`default_nettype wire

// File: source/hockeyTop.sv
`timescale 1ns/1ps
`default_nettype none

module hockeyTop
#(
        parameter int stepTicks = 100,
        parameter int blinkTicks = 25
)
(
        input wire clk,
        input wire rst,
        input wire hockeyPkg::playerCtrl playerA,
        input wire hockeyPkg::playerCtrl playerB,
        output logic ledA,
        output logic ledB,
        output logic [4:0] ledX,
        output hockeyPkg::segCode ssd0,
        output hockeyPkg::segCode ssd1,
        output hockeyPkg::segCode ssd2,
        output hockeyPkg::segCode ssd4,
        output hockeyPkg::puckPos pos
);
        import hockeyPkg::*;

        gamePhase phase;
        score scoreA;
        score scoreB;
        puckCmd cmd;
        logic toB;
        playerCtrl ctrl;

        // **************************************************
        // Game core
        // **************************************************

        gameControl #(
                .stepTicks(stepTicks),
                .blinkTicks(blinkTicks)
        ) gameControl_inst (
                .clk(clk), .rst(rst), .playerA(playerA), .playerB(playerB), .pos(pos),
                .phase(phase), .scoreA(scoreA), .scoreB(scoreB),
                .cmd(cmd), .toB(toB), .ctrl(ctrl)
        );

        puckMotion puckMotion_inst (
                .clk(clk), .rst(rst), .cmd(cmd), .toB(toB), .ctrl(ctrl), .pos(pos)
        );

        // **************************************************
        // Board outputs
        // **************************************************

        scoreDisplay scoreDisplay_inst (
                .phase(phase), .scoreA(scoreA), .scoreB(scoreB), .pos(pos),
                .ssd0(ssd0), .ssd1(ssd1), .ssd2(ssd2), .ssd4(ssd4)
        );

        ledDriver ledDriver_inst (
                .phase(phase), .pos(pos), .ledA(ledA), .ledB(ledB), .ledX(ledX)
        );

endmodule

`default_nettype wire

// File: source/ledDriver.sv
`timescale 1ns/1ps
`default_nettype none

module ledDriver
(
        input wire hockeyPkg::gamePhase phase,
        input wire hockeyPkg::puckPos pos,
        output logic ledA,
        output logic ledB,
        output logic [4:0] ledX
);
        import hockeyPkg::*;

        localparam logic [4:0] bothEnds = 5'b10001;

        always_comb
        begin
                ledA = (phase == waitHitA);     // The serving player is prompted.
                ledB = (phase == waitHitB);
                case (phase)
                        sendToA, sendToB, respondA, respondB:
                                ledX = 5'b00001 << pos.x;
                        goalA, goalB, finish:
                                ledX = bothEnds;
                        default:
                                ledX = '0;      // Blink is the dark half of the end display.
                endcase
        end

endmodule

`default_nettype wire

// File: source/puckMotion.sv
`timescale 1ns/1ps
`default_nettype none

module puckMotion
(
        input wire clk,
        input wire rst,
        input wire hockeyPkg::puckCmd cmd,
        input wire toB,
        input wire hockeyPkg::playerCtrl ctrl,
        output hockeyPkg::puckPos pos
);
        import hockeyPkg::*;

        localparam vertDir dirUp = 2'd1;
        localparam vertDir dirDown = 2'd2;

        typedef struct packed {
                coordY y;
                vertDir dir;
        } rowMove;

        vertDir dir;
        rowMove rowStep;
        rowMove rowRet;

        // One row in the given direction, reflecting off the top and bottom rows.
        function automatic rowMove moveRow(input coordY y, input vertDir d);
                rowMove m;
                m.y = y;
                m.dir = d;
                if (d == dirDown)
                begin
                        if (y == 3'd0)
                        begin
                                m.dir = dirUp;
                                m.y = 3'd1;
                        end
                        else
                                m.y = y - 3'd1;
                end
                else if (d == dirUp)
                begin
                        if (y == lastRow)
                        begin
                                m.dir = dirDown;
                                m.y = lastRow - 3'd1;
                        end
                        else
                                m.y = y + 3'd1;
                end
                return m;
        endfunction

        assign rowStep = moveRow(pos.y, dir);
        assign rowRet = moveRow(pos.y, ctrl.dir);     // The responder sets a new slope.

        always_ff @(posedge clk or posedge rst)
        begin
                if (rst)
                begin
                        pos <= '0;
                        dir <= '0;
                end
                else
                begin
                        case (cmd)
                                serve:
                                begin
                                        pos.x <= toB ? 3'd0 : lastCol;   // Striker's home column.
                                        pos.y <= ctrl.row;
                                        dir <= ctrl.dir;
                                end
                                step:
                                begin
                                        pos.x <= toB ? pos.x + 3'd1 : pos.x - 3'd1;
                                        pos.y <= rowStep.y;
                                        dir <= rowStep.dir;
                                end
                                ret:
                                begin
                                        pos.x <= toB ? 3'd1 : lastCol - 3'd1;
                                        pos.y <= rowRet.y;
                                        dir <= rowRet.dir;
                                end
                                default:
                                begin
                                        pos <= pos;
                                        dir <= dir;
                                end
                        endcase
                end
        end

endmodule

`default_nettype wire

// File: source/scoreDisplay.sv
`timescale 1ns/1ps
`default_nettype none

module scoreDisplay
(
        input wire hockeyPkg::gamePhase phase,
        input wire hockeyPkg::score scoreA,
        input wire hockeyPkg::score scoreB,
        input wire hockeyPkg::puckPos pos,
        output hockeyPkg::segCode ssd0,
        output hockeyPkg::segCode ssd1,
        output hockeyPkg::segCode ssd2,
        output hockeyPkg::segCode ssd4
);
        import hockeyPkg::*;

        logic showTally;

        function automatic segCode digitOf(input coordY value);
                case (value)
                        3'd0:
                                return segZero;
                        3'd1:
                                return segOne;
                        3'd2:
                                return segTwo;
                        3'd3:
                                return segThree;
                        3'd4:
                                return segFour;
                        default:
                                return segBlank;
                endcase
        endfunction

        // The tally reads B, dash, A from the right.
        always_comb
        begin
                showTally = phase inside {showScore, goalA, goalB, finish, blink};
                if (showTally)
                begin
                        ssd0 = digitOf(coordY'(scoreB));
                        ssd1 = segDash;
                        ssd2 = digitOf(coordY'(scoreA));
                end
                else
                begin
                        ssd0 = segBlank;
                        ssd1 = segBlank;
                        ssd2 = segBlank;
                end
                if (phase != idle)
                        ssd4 = digitOf(pos.y);  // Puck row.
                else
                        ssd4 = segBlank;
        end

endmodule

`default_nettype wire

// File: sources.f
source/hockeyPkg.sv
source/puckMotion.sv
source/gameControl.sv
source/scoreDisplay.sv
source/ledDriver.sv
source/hockeyTop.sv
bench/clockGen.sv
bench/hockeyTb.sv
